// File: source/l2_defines.svh
// L2 subsystem sizing macros
// Address and line widths, store depth, request buffer depth and hit delay
`ifndef L2_DEFINES_SVH
`define L2_DEFINES_SVH

// Byte address width
`define L2_ADDR_W      32

// One cache line in bits, 64 bytes
`define L2_LINE_W      512

// Store depth in lines, indexed by address bits 11 down to 6
`define L2_STORE_LINES 64

// Entries in the L2 request buffer
`define L2_BUF_DEPTH   3

// Countdown loaded into a freshly accepted entry
`define L2_HIT_DELAY   2

// Write-back buffer tag width
`define L2_WBB_TAG_W   4

`endif

// File: source/l2_pkg.sv
// L2 subsystem package
// Width typedefs plus request, answer and arbiter source enums
`include "l2_defines.svh"

package l2_pkg;

  // Datapath widths
  typedef logic [`L2_ADDR_W-1:0]    l2_addr_t;
  typedef logic [`L2_LINE_W-1:0]    l2_line_t;
  typedef logic [63:0]              l2_dword_t;
  typedef logic [`L2_WBB_TAG_W-1:0] wbb_tag_t;

  // Request kinds seen by the L2 model
  typedef enum logic [1:0] {
    IReadLine,
    DReadLine,
    DWriteLine,
    PTWLoad
  } l2_req_type_e;

  // Answer kinds, one per request kind
  typedef enum logic [1:0] {
    AnsILineRead,
    AnsDLineRead,
    AnsDLineWritten,
    AnsPTWLoad
  } l2_ans_type_e;

  // Requesters, also the arbiter's last-grant state
  typedef enum logic [1:0] {
    SrcI,
    SrcD,
    SrcPtw
  } l2_src_e;

endpackage

// File: source/l2_req_arbiter.sv
// Round-robin L2 request arbiter
// Picks one of I-cache, D-cache and PTW per cycle and forwards it to the L2 model
module l2_req_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Instruction cache
  input  logic                 i_valid_i,
  input  l2_pkg::l2_addr_t     i_addr_i,
  output logic                 i_ready_o,
  // Data cache
  input  logic                 d_valid_i,
  input  logic                 d_write_i,
  input  l2_pkg::l2_addr_t     d_addr_i,
  input  l2_pkg::l2_line_t     d_line_i,
  input  l2_pkg::wbb_tag_t     d_wbb_tag_i,
  output logic                 d_ready_o,
  // Page-table walker
  input  logic                 ptw_valid_i,
  input  l2_pkg::l2_addr_t     ptw_addr_i,
  output logic                 ptw_ready_o,
  // Forwarded request
  output logic                 req_valid_o,
  output l2_pkg::l2_req_type_e req_type_o,
  output l2_pkg::l2_addr_t     req_addr_o,
  output l2_pkg::l2_line_t     req_line_o,
  output l2_pkg::wbb_tag_t     req_wbb_tag_o,
  input  logic                 req_ready_i
);
  import l2_pkg::*;

  localparam int NUM_SRC = 3;

  l2_src_e              last_q;
  l2_src_e              sel;
  logic                 sel_valid;
  logic [NUM_SRC-1:0]   src_valid;
  logic                 xfer;

  // Bit position follows the l2_src_e encoding
  assign src_valid = {ptw_valid_i, d_valid_i, i_valid_i};

  // Scan backwards so the source closest after the last grant wins
  always_comb begin
    int cand;
    sel       = last_q;
    sel_valid = 1'b0;
    for (int off = NUM_SRC; off >= 1; off--) begin
      cand = (int'(last_q) + off) % NUM_SRC;
      if (src_valid[cand]) begin
        sel       = l2_src_e'(cand);
        sel_valid = 1'b1;
      end
    end
  end

  // Request type and fields of the chosen source
  always_comb begin
    req_type_o    = IReadLine;
    req_addr_o    = i_addr_i;
    req_line_o    = '0;
    req_wbb_tag_o = '0;
    case (sel)
      SrcD: begin
        req_type_o    = d_write_i ? DWriteLine : DReadLine;
        req_addr_o    = d_addr_i;
        req_line_o    = d_line_i;
        req_wbb_tag_o = d_wbb_tag_i;
      end
      SrcPtw: begin
        req_type_o = PTWLoad;
        req_addr_o = ptw_addr_i;
      end
      default: begin
        req_type_o = IReadLine;
      end
    endcase
  end

  assign req_valid_o = sel_valid;
  assign xfer        = sel_valid && req_ready_i;

  // Only the granted source sees ready, and only when the model takes it
  assign i_ready_o   = xfer && (sel == SrcI);
  assign d_ready_o   = xfer && (sel == SrcD);
  assign ptw_ready_o = xfer && (sel == SrcPtw);

  // Last grant, starts at PTW so I goes first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= SrcPtw;
    end else if (xfer) begin
      last_q <= sel;
    end
  end

  // Never more than one requester granted
  a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({i_ready_o, d_ready_o, ptw_ready_o}));

endmodule

// File: source/l2_line_store.sv
// L2 line store
// Line-wide backing memory with line and doubleword reads and a line write
`include "l2_defines.svh"

module l2_line_store (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Combinational read port
  input  l2_pkg::l2_addr_t  rd_addr_i,
  output l2_pkg::l2_line_t  rd_line_o,
  output l2_pkg::l2_dword_t rd_dword_o,
  // Line write port
  input  logic              wr_en_i,
  input  l2_pkg::l2_addr_t  wr_addr_i,
  input  l2_pkg::l2_line_t  wr_line_i
);
  import l2_pkg::*;

  // Byte offset inside a line, 6 bits for 64 bytes
  localparam int OFF_W    = $clog2(`L2_LINE_W / 8);
  // Line index above the offset
  localparam int IDX_W    = $clog2(`L2_STORE_LINES);
  // Doubleword offset, 8 bytes each
  localparam int DW_OFF   = 3;
  localparam int DW_SEL_W = $clog2(`L2_LINE_W / 64);

  l2_line_t            mem_q [`L2_STORE_LINES];
  logic [IDX_W-1:0]    rd_idx;
  logic [IDX_W-1:0]    wr_idx;
  logic [DW_SEL_W-1:0] dw_sel;

  // Address bits 11:6 pick the line, 5:3 the doubleword
  assign rd_idx = rd_addr_i[OFF_W +: IDX_W];
  assign wr_idx = wr_addr_i[OFF_W +: IDX_W];
  assign dw_sel = rd_addr_i[DW_OFF +: DW_SEL_W];

  assign rd_line_o  = mem_q[rd_idx];
  // Doubleword 0 sits in the low bits of the line
  assign rd_dword_o = rd_line_o[64*dw_sel +: 64];

  // Whole store reads as zero after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `L2_STORE_LINES; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      mem_q[wr_idx] <= wr_line_i;
    end
  end

endmodule

// File: source/l2_cache_model.sv
// Behavioural L2 cache model
// Buffers requests for a fixed hit delay and answers them in order
// from a registered answer port that holds under back-pressure
`include "l2_defines.svh"

module l2_cache_model (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Request channel from the arbiter
  input  logic                 req_valid_i,
  input  l2_pkg::l2_req_type_e req_type_i,
  input  l2_pkg::l2_addr_t     req_addr_i,
  input  l2_pkg::l2_line_t     req_line_i,
  input  l2_pkg::wbb_tag_t     req_wbb_tag_i,
  output logic                 req_ready_o,
  // Answer channel
  output logic                 ans_valid_o,
  output l2_pkg::l2_ans_type_e ans_type_o,
  output l2_pkg::l2_addr_t     ans_addr_o,
  output l2_pkg::l2_line_t     ans_line_o,
  output l2_pkg::l2_dword_t    ans_data_o,
  output l2_pkg::wbb_tag_t     ans_wbb_tag_o,
  input  logic                 ans_ready_i
);
  import l2_pkg::*;

  localparam int DEPTH = `L2_BUF_DEPTH;
  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int OCC_W = $clog2(DEPTH + 1);
  localparam int CNT_W = (`L2_HIT_DELAY > 0) ? $clog2(`L2_HIT_DELAY + 1) : 1;

  // Request buffer, age 0 is the oldest entry
  logic [DEPTH-1:0] ent_valid_q;
  l2_req_type_e     ent_type_q [DEPTH];
  l2_addr_t         ent_addr_q [DEPTH];
  l2_line_t         ent_line_q [DEPTH];
  wbb_tag_t         ent_tag_q  [DEPTH];
  logic [CNT_W-1:0] ent_cnt_q  [DEPTH];
  logic [IDX_W-1:0] ent_age_q  [DEPTH];

  logic [IDX_W-1:0] free_idx;
  logic             free_found;
  logic [IDX_W-1:0] leave_idx;
  logic             leave_found;
  logic [OCC_W-1:0] occupancy;
  logic             stall;
  logic             active_q;
  logic             deq;
  logic             enq;
  logic [IDX_W-1:0] enq_idx;
  logic [IDX_W-1:0] enq_age;

  // Store access for the leaving entry
  l2_line_t         st_line;
  l2_dword_t        st_dword;
  logic             st_wr;

  // Lowest free slot
  always_comb begin
    free_idx   = '0;
    free_found = 1'b0;
    for (int k = DEPTH - 1; k >= 0; k--) begin
      if (!ent_valid_q[k]) begin
        free_idx   = IDX_W'(k);
        free_found = 1'b1;
      end
    end
  end

  // Oldest entry whose countdown has expired
  always_comb begin
    leave_idx   = '0;
    leave_found = 1'b0;
    for (int k = 0; k < DEPTH; k++) begin
      if (ent_valid_q[k] && ent_cnt_q[k] == '0 &&
          (!leave_found || ent_age_q[k] < ent_age_q[leave_idx])) begin
        leave_idx   = IDX_W'(k);
        leave_found = 1'b1;
      end
    end
  end

  assign occupancy = OCC_W'($countones(ent_valid_q));

  // Held answer not taken, whole buffer freezes
  assign stall = ans_valid_o && !ans_ready_i;
  assign deq   = leave_found && !stall && !flush_i;

  // Free slot, or the slot that empties on this edge
  assign req_ready_o = active_q && !stall && (free_found || leave_found);
  assign enq         = req_valid_i && req_ready_o && !flush_i;
  assign enq_idx     = free_found ? free_idx : leave_idx;
  // New entry is the youngest of what stays
  assign enq_age     = IDX_W'(occupancy - OCC_W'(deq));

  // Keeps ready low for the first cycle out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
    end
  end

  // Entry control: valid, countdown and age
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ent_valid_q <= '0;
      for (int k = 0; k < DEPTH; k++) begin
        ent_cnt_q[k] <= '0;
        ent_age_q[k] <= '0;
      end
    end else if (flush_i) begin
      ent_valid_q <= '0;
    end else if (!stall) begin
      for (int k = 0; k < DEPTH; k++) begin
        if (ent_valid_q[k] && ent_cnt_q[k] != '0) begin
          ent_cnt_q[k] <= ent_cnt_q[k] - 1'b1;
        end
        // Younger entries move up behind the one leaving
        if (deq && ent_valid_q[k] && ent_age_q[k] > ent_age_q[leave_idx]) begin
          ent_age_q[k] <= ent_age_q[k] - 1'b1;
        end
      end
      if (deq) begin
        ent_valid_q[leave_idx] <= 1'b0;
      end
      // Written last so it can reuse the slot just freed
      if (enq) begin
        ent_valid_q[enq_idx] <= 1'b1;
        ent_cnt_q[enq_idx]   <= CNT_W'(`L2_HIT_DELAY);
        ent_age_q[enq_idx]   <= enq_age;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (enq) begin
      ent_type_q[enq_idx] <= req_type_i;
      ent_addr_q[enq_idx] <= req_addr_i;
      ent_line_q[enq_idx] <= req_line_i;
      ent_tag_q[enq_idx]  <= req_wbb_tag_i;
    end
  end

  // Store is touched in dequeue order, reads see every older write
  assign st_wr = deq && (ent_type_q[leave_idx] == DWriteLine);

  l2_line_store u_line_store (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_addr_i  (ent_addr_q[leave_idx]),
    .rd_line_o  (st_line),
    .rd_dword_o (st_dword),
    .wr_en_i    (st_wr),
    .wr_addr_i  (ent_addr_q[leave_idx]),
    .wr_line_i  (ent_line_q[leave_idx])
  );

  // Answer valid, held until the consumer takes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ans_valid_o <= 1'b0;
    end else if (deq) begin
      ans_valid_o <= 1'b1;
    end else if (ans_ready_i) begin
      ans_valid_o <= 1'b0;
    end
  end

  // Answer fields, unused ones zero
  always_ff @(posedge clk_i) begin
    if (deq) begin
      ans_addr_o    <= ent_addr_q[leave_idx];
      ans_line_o    <= '0;
      ans_data_o    <= '0;
      ans_wbb_tag_o <= '0;
      case (ent_type_q[leave_idx])
        IReadLine: begin
          ans_type_o <= AnsILineRead;
          ans_line_o <= st_line;
        end
        DReadLine: begin
          ans_type_o <= AnsDLineRead;
          ans_line_o <= st_line;
        end
        DWriteLine: begin
          ans_type_o    <= AnsDLineWritten;
          ans_wbb_tag_o <= ent_tag_q[leave_idx];
        end
        default: begin
          ans_type_o <= AnsPTWLoad;
          ans_data_o <= st_dword;
        end
      endcase
    end
  end

  // Stalled buffer neither takes nor releases an entry
  a_stall_frozen: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall && !flush_i |=> $stable(ent_valid_q));

  // Held answer keeps valid and every field until taken
  a_ans_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall |=> ans_valid_o && $stable(ans_type_o) && $stable(ans_addr_o) &&
              $stable(ans_line_o) && $stable(ans_data_o) && $stable(ans_wbb_tag_o));

endmodule

// File: source/l2_subsys.sv
// L2 subsystem top
// Round-robin arbiter feeding the behavioural L2 cache model
module l2_subsys (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Instruction cache
  input  logic                 i_valid_i,
  input  l2_pkg::l2_addr_t     i_addr_i,
  output logic                 i_ready_o,
  // Data cache
  input  logic                 d_valid_i,
  input  logic                 d_write_i,
  input  l2_pkg::l2_addr_t     d_addr_i,
  input  l2_pkg::l2_line_t     d_line_i,
  input  l2_pkg::wbb_tag_t     d_wbb_tag_i,
  output logic                 d_ready_o,
  // Page-table walker
  input  logic                 ptw_valid_i,
  input  l2_pkg::l2_addr_t     ptw_addr_i,
  output logic                 ptw_ready_o,
  // Answer channel
  output logic                 ans_valid_o,
  output l2_pkg::l2_ans_type_e ans_type_o,
  output l2_pkg::l2_addr_t     ans_addr_o,
  output l2_pkg::l2_line_t     ans_line_o,
  output l2_pkg::l2_dword_t    ans_data_o,
  output l2_pkg::wbb_tag_t     ans_wbb_tag_o,
  input  logic                 ans_ready_i
);
  import l2_pkg::*;

  // Arbiter to model request
  logic         req_valid;
  l2_req_type_e req_type;
  l2_addr_t     req_addr;
  l2_line_t     req_line;
  wbb_tag_t     req_wbb_tag;
  logic         req_ready;

  l2_req_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .i_valid_i     (i_valid_i),
    .i_addr_i      (i_addr_i),
    .i_ready_o     (i_ready_o),
    .d_valid_i     (d_valid_i),
    .d_write_i     (d_write_i),
    .d_addr_i      (d_addr_i),
    .d_line_i      (d_line_i),
    .d_wbb_tag_i   (d_wbb_tag_i),
    .d_ready_o     (d_ready_o),
    .ptw_valid_i   (ptw_valid_i),
    .ptw_addr_i    (ptw_addr_i),
    .ptw_ready_o   (ptw_ready_o),
    .req_valid_o   (req_valid),
    .req_type_o    (req_type),
    .req_addr_o    (req_addr),
    .req_line_o    (req_line),
    .req_wbb_tag_o (req_wbb_tag),
    .req_ready_i   (req_ready)
  );

  l2_cache_model u_cache_model (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .req_valid_i   (req_valid),
    .req_type_i    (req_type),
    .req_addr_i    (req_addr),
    .req_line_i    (req_line),
    .req_wbb_tag_i (req_wbb_tag),
    .req_ready_o   (req_ready),
    .ans_valid_o   (ans_valid_o),
    .ans_type_o    (ans_type_o),
    .ans_addr_o    (ans_addr_o),
    .ans_line_o    (ans_line_o),
    .ans_data_o    (ans_data_o),
    .ans_wbb_tag_o (ans_wbb_tag_o),
    .ans_ready_i   (ans_ready_i)
  );

endmodule

// File: tb/tb_l2_subsys.sv
// Testbench for the L2 subsystem
// Random requester traffic checked against a mirror of the line store
`include "l2_defines.svh"

module tb_l2_subsys;
  timeunit 1ns;
  timeprecision 1ps;
  import l2_pkg::*;

  typedef struct packed {
    l2_req_type_e typ;
    l2_addr_t     addr;
    l2_line_t     line;
    wbb_tag_t     tag;
  } req_t;

  typedef struct packed {
    l2_ans_type_e typ;
    l2_addr_t     addr;
    l2_line_t     line;
    l2_dword_t    dword;
    wbb_tag_t     tag;
  } ans_t;

  logic         clk_i       = 1'b0;
  logic         rst_ni;
  logic         flush_i;
  logic         i_valid_i   = 1'b0;
  l2_addr_t     i_addr_i    = '0;
  logic         i_ready_o;
  logic         d_valid_i   = 1'b0;
  logic         d_write_i   = 1'b0;
  l2_addr_t     d_addr_i    = '0;
  l2_line_t     d_line_i    = '0;
  wbb_tag_t     d_wbb_tag_i = '0;
  logic         d_ready_o;
  logic         ptw_valid_i = 1'b0;
  l2_addr_t     ptw_addr_i  = '0;
  logic         ptw_ready_o;
  logic         ans_valid_o;
  l2_ans_type_e ans_type_o;
  l2_addr_t     ans_addr_o;
  l2_line_t     ans_line_o;
  l2_dword_t    ans_data_o;
  wbb_tag_t     ans_wbb_tag_o;
  logic         ans_ready_i = 1'b1;

  // Pending requests per source plus expected answers and accepted history
  req_t        q_i [$];
  req_t        q_d [$];
  req_t        q_p [$];
  ans_t        exp_q [$];
  req_t        hist [$];
  l2_line_t    mirror [`L2_STORE_LINES];
  l2_src_e     last_src;
  logic        stall_mode;
  logic        prev_stall;
  ans_t        held;
  logic [31:0] stim_seed;
  logic [31:0] rdy_seed;
  string       cur_test;

  l2_subsys DUT (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_seed = xorshift32(stim_seed);
    return stim_seed;
  endfunction

  function automatic l2_line_t rand_line();
    l2_line_t l;
    for (int w = 0; w < `L2_LINE_W / 32; w++) begin
      l[32*w +: 32] = next_rand();
    end
    return l;
  endfunction

  // Expected answer from the mirror with the line at address bits 11:6 and the doubleword at 5:3
  function automatic ans_t l2_expect(input req_t r);
    ans_t     a;
    l2_line_t l;
    a      = '0;
    a.addr = r.addr;
    l      = mirror[r.addr[11:6]];
    case (r.typ)
      IReadLine: begin
        a.typ  = AnsILineRead;
        a.line = l;
      end
      DReadLine: begin
        a.typ  = AnsDLineRead;
        a.line = l;
      end
      DWriteLine: begin
        a.typ = AnsDLineWritten;
        a.tag = r.tag;
      end
      default: begin
        a.typ   = AnsPTWLoad;
        a.dword = l[64*r.addr[5:3] +: 64];
      end
    endcase
    return a;
  endfunction

  // Rebuilds the mirror by replaying only the writes that reached the store
  function automatic void rebuild_mirror();
    for (int k = 0; k < `L2_STORE_LINES; k++) begin
      mirror[k] = '0;
    end
    foreach (hist[k]) begin
      if (hist[k].typ == DWriteLine) begin
        mirror[hist[k].addr[11:6]] = hist[k].line;
      end
    end
  endfunction

  // Round-robin successor in the order I, D, PTW
  function automatic l2_src_e next_src(input l2_src_e s);
    case (s)
      SrcI:    return SrcD;
      SrcD:    return SrcPtw;
      default: return SrcI;
    endcase
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_ans_type(input string what, input l2_ans_type_e e, input l2_ans_type_e a);
    if (e !== a) begin
      report_error($sformatf("FAIL %s %s: expected %s actual %s", cur_test, what,
                             e.name(), a.name()));
    end
  endtask

  task automatic check_addr(input string what, input l2_addr_t e, input l2_addr_t a);
    if (e !== a) begin
      report_error($sformatf("FAIL %s %s: expected %h actual %h", cur_test, what, e, a));
    end
  endtask

  task automatic check_line(input string what, input l2_line_t e, input l2_line_t a);
    if (e !== a) begin
      report_error($sformatf("FAIL %s %s: expected %h actual %h", cur_test, what, e, a));
    end
  endtask

  task automatic check_dword(input string what, input l2_dword_t e, input l2_dword_t a);
    if (e !== a) begin
      report_error($sformatf("FAIL %s %s: expected %h actual %h", cur_test, what, e, a));
    end
  endtask

  task automatic check_tag(input string what, input wbb_tag_t e, input wbb_tag_t a);
    if (e !== a) begin
      report_error($sformatf("FAIL %s %s: expected %h actual %h", cur_test, what, e, a));
    end
  endtask

  task automatic check_src(input string what, input l2_src_e e, input l2_src_e a);
    if (e !== a) begin
      report_error($sformatf("FAIL %s %s: expected %s actual %s", cur_test, what,
                             e.name(), a.name()));
    end
  endtask

  task automatic check_ans(input string what, input ans_t e, input ans_t a);
    check_ans_type({what, " type"}, e.typ, a.typ);
    check_addr({what, " addr"}, e.addr, a.addr);
    check_line({what, " line"}, e.line, a.line);
    check_dword({what, " dword"}, e.dword, a.dword);
    check_tag({what, " tag"}, e.tag, a.tag);
  endtask

  task automatic push_req(input l2_req_type_e typ, input l2_addr_t addr, input l2_line_t line,
                          input wbb_tag_t tag);
    req_t r;
    r.typ  = typ;
    r.addr = addr;
    r.line = line;
    r.tag  = tag;
    case (typ)
      IReadLine: q_i.push_back(r);
      PTWLoad:   q_p.push_back(r);
      default:   q_d.push_back(r);
    endcase
  endtask

  // Queues n random requests per source with addresses inside the 4 KiB store
  task automatic queue_round(input int n);
    logic [31:0] r;
    @(negedge clk_i);
    for (int k = 0; k < n; k++) begin
      r = next_rand();
      push_req(IReadLine, l2_addr_t'(r[19:8]), '0, '0);
      r = next_rand();
      push_req(r[0] ? DWriteLine : DReadLine, l2_addr_t'(r[19:8]), rand_line(),
               wbb_tag_t'(r[7:4]));
      r = next_rand();
      push_req(PTWLoad, l2_addr_t'(r[19:8]), '0, '0);
    end
  endtask

  // Until every queued request is answered and the answer port is empty
  task automatic wait_idle(input int limit);
    int cycles;
    cycles = 0;
    while (q_i.size() + q_d.size() + q_p.size() + exp_q.size() != 0 || ans_valid_o) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > limit) begin
        report_error($sformatf("Timed out in %s waiting for requests to drain", cur_test));
      end
    end
  endtask

  // Until every requester has handed over its queued requests
  task automatic drain_sources(input int limit);
    int cycles;
    cycles = 0;
    while (q_i.size() + q_d.size() + q_p.size() != 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > limit) begin
        report_error($sformatf("Timed out in %s waiting for requesters to drain", cur_test));
      end
    end
  endtask

  // Requesters hold each request until its ready is seen
  always @(posedge clk_i) begin
    if (i_valid_i && i_ready_o) q_i.delete(0);
    if (d_valid_i && d_ready_o) q_d.delete(0);
    if (ptw_valid_i && ptw_ready_o) q_p.delete(0);
    i_valid_i   <= q_i.size() != 0;
    d_valid_i   <= q_d.size() != 0;
    ptw_valid_i <= q_p.size() != 0;
    if (q_i.size() != 0) i_addr_i <= q_i[0].addr;
    if (q_p.size() != 0) ptw_addr_i <= q_p[0].addr;
    if (q_d.size() != 0) begin
      d_write_i   <= q_d[0].typ == DWriteLine;
      d_addr_i    <= q_d[0].addr;
      d_line_i    <= q_d[0].line;
      d_wbb_tag_i <= q_d[0].tag;
    end
  end

  // Answer consumer with random back-pressure in stall mode
  always @(posedge clk_i) begin
    rdy_seed = xorshift32(rdy_seed);
    ans_ready_i <= stall_mode ? rdy_seed[9] : 1'b1;
  end

  // Scoreboard for hold checks, answer compare, grant order and expected answers
  always @(posedge clk_i) begin
    req_t    r;
    ans_t    got;
    ans_t    e;
    logic    granted;
    l2_src_e src;
    int      keep;
    if (rst_ni) begin
      got.typ   = ans_type_o;
      got.addr  = ans_addr_o;
      got.line  = ans_line_o;
      got.dword = ans_data_o;
      got.tag   = ans_wbb_tag_o;
      if (prev_stall) begin
        if (!ans_valid_o) report_error("Answer valid dropped while the answer was stalled");
        check_ans("held answer", held, got);
      end
      prev_stall = ans_valid_o && !ans_ready_i;
      held       = got;
      if (prev_stall && (i_ready_o || d_ready_o || ptw_ready_o)) begin
        report_error("A requester was granted while the answer was stalled");
      end
      if (ans_valid_o && ans_ready_i) begin
        if (exp_q.size() == 0) report_error("An answer arrived with no request outstanding");
        e = exp_q.pop_front();
        check_ans("answer", e, got);
      end
      r       = '0;
      src     = last_src;
      granted = 1'b1;
      if (i_valid_i && i_ready_o) begin
        src    = SrcI;
        r.typ  = IReadLine;
        r.addr = i_addr_i;
      end else if (d_valid_i && d_ready_o) begin
        src    = SrcD;
        r.typ  = d_write_i ? DWriteLine : DReadLine;
        r.addr = d_addr_i;
        r.line = d_line_i;
        r.tag  = d_wbb_tag_i;
      end else if (ptw_valid_i && ptw_ready_o) begin
        src    = SrcPtw;
        r.typ  = PTWLoad;
        r.addr = ptw_addr_i;
      end else begin
        granted = 1'b0;
      end
      if (granted) begin
        if (i_valid_i && d_valid_i && ptw_valid_i) begin
          check_src("grant order", next_src(last_src), src);
        end
        last_src = src;
      end
      // Flush keeps only a stalled answer and drops a request taken on this edge
      if (flush_i) begin
        keep = prev_stall ? 1 : 0;
        while (exp_q.size() > keep) begin
          e = exp_q.pop_back();
          r = hist.pop_back();
        end
        rebuild_mirror();
      end else if (granted) begin
        exp_q.push_back(l2_expect(r));
        hist.push_back(r);
        if (r.typ == DWriteLine) mirror[r.addr[11:6]] = r.line;
      end
    end
  end

  initial begin
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    stim_seed  = 32'h92bb_250b;
    rdy_seed   = xorshift32(32'h92bb_250b);
    stall_mode = 1'b0;
    prev_stall = 1'b0;
    held       = '0;
    last_src   = SrcPtw;
    cur_test   = "reset";
    rebuild_mirror();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // Writes to lines 1, 5, 9 and 13 and then reads that include two untouched lines
    cur_test = "write_read";
    @(negedge clk_i);
    for (int k = 0; k < 4; k++) begin
      push_req(DWriteLine, l2_addr_t'((4 * k + 1) << 6), rand_line(), wbb_tag_t'(k + 3));
    end
    wait_idle(200);
    @(negedge clk_i);
    for (int k = 0; k < 6; k++) begin
      push_req(IReadLine, l2_addr_t'((4 * k + 1) << 6), '0, '0);
      push_req(DReadLine, l2_addr_t'(((4 * k + 1) << 6) + 8 * k), '0, '0);
    end
    wait_idle(200);

    cur_test = "ptw_load";
    @(negedge clk_i);
    for (int k = 0; k < 8; k++) begin
      push_req(PTWLoad, l2_addr_t'(((4 * (k % 4) + 1) << 6) | (k << 3)), '0, '0);
    end
    wait_idle(200);

    cur_test = "rotation";
    queue_round(6);
    wait_idle(500);

    cur_test   = "back_pressure";
    stall_mode = 1'b1;
    queue_round(10);
    wait_idle(2000);

    // Flush while answers are stalled and the buffer holds requests
    cur_test = "flush";
    queue_round(4);
    repeat (6) @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    wait_idle(2000);
    stall_mode = 1'b0;

    cur_test = "read_back";
    @(negedge clk_i);
    for (int k = 0; k < `L2_STORE_LINES; k++) begin
      push_req(DReadLine, l2_addr_t'(k << 6), '0, '0);
    end
    drain_sources(1000);
    // Without back-pressure the last answer is taken within the hit delay plus two edges
    repeat (`L2_HIT_DELAY + 2) @(negedge clk_i);

    if (exp_q.size() != 0 || ans_valid_o) begin
      report_error("Answers were missing, late or extra at the end of the run");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

// File: l2_subsys.f
+incdir+source
source/l2_pkg.sv
source/l2_req_arbiter.sv
source/l2_line_store.sv
source/l2_cache_model.sv
source/l2_subsys.sv
tb/tb_l2_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Build the L2 subsystem testbench with Verilator, run it, and scan the log
verilator --binary --assert --top-module tb_l2_subsys -f l2_subsys.f > build.log 2>&1 ||
  { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_l2_subsys > sim.log 2>&1
grep -q "Simulation failed" sim.log && { echo "Test FAILED, see sim.log"; exit 1; }
grep -q "Simulation completed successfully" sim.log ||
  { echo "Run ended without a result, see sim.log"; exit 1; }
echo "Test PASSED"
